//--- include/vid_defs.svh
// line geometry, pixel rate, flash period, buffer depth and register address macros
`ifndef VID_DEFS_SVH
`define VID_DEFS_SVH

// pixels per line, total and active
`define VID_H_TOTAL 64
`define VID_H_ACTIVE 32

// clocks per pixel strobe
`define VID_CLK_PER_PIX 2

// lines per flash phase
`define VID_FLASH_LINES 4

// entries in each stream buffer
`define VID_BUF_DEPTH 8

// host register addresses
`define VID_REG_CTRL 2'd0
`define VID_REG_BORDER 2'd1
`define VID_REG_STATUS 2'd2

`endif

//--- design/vid_pkg.sv
// render mode enum and payload types of the video pipeline
`default_nettype none

package vid_pkg;

	// render modes, encoded as CTRL bits 1:0
	typedef enum logic [1:0] {
		RM_ZX = 2'd0,
		RM_HC = 2'd1,
		RM_XC = 2'd2,
		RM_TX = 2'd3
	} render_mode_t;

	// graphics word
	// low half is bitmap or pixels, high half is attributes
	typedef logic [31:0] gfx_word_t;

	// overlay index, zero low nibble means transparent
	typedef logic [7:0] tile_byte_t;

	// palette index
	typedef logic [7:0] pix_t;

endpackage

`default_nettype wire

//--- design/vid_config_regs.sv
// host register block: CTRL, BORDER, sticky underrun STATUS, four-phase req/ack
`timescale 1ns/10ps
`default_nettype none

`include "vid_defs.svh"

module vid_config_regs (
	input  wire                      clk,
	input  wire                      rst,
	input  wire                      host_req,
	input  wire                      host_we,
	input  wire [1:0]                host_addr,
	input  wire [7:0]                host_wdata,
	input  wire                      underrun,
	output logic                     host_ack,
	output logic [7:0]               host_rdata,
	output vid_pkg::render_mode_t    mode,
	output logic                     hires,
	output logic                     nogfx,
	output logic [3:0]               palsel,
	output vid_pkg::pix_t            border
);

	logic [7:0] ctrl_q;
	logic       underrun_q;
	logic       access;

	// one access per handshake, on the req rise not yet acked
	assign access = host_req && !host_ack;

	// CTRL fields
	assign mode   = vid_pkg::render_mode_t'(ctrl_q[1:0]);
	assign hires  = ctrl_q[2];
	assign nogfx  = ctrl_q[3];
	assign palsel = ctrl_q[7:4];

	always_ff @(posedge clk) begin
		if (rst) begin
			host_ack   <= 1'b0;
			ctrl_q     <= 8'h00;
			border     <= 8'h00;
			underrun_q <= 1'b0;
		end else begin
			// ack follows req one cycle late, both edges
			host_ack <= host_req;
			if (access && host_we) begin
				if (host_addr == `VID_REG_CTRL)
					ctrl_q <= host_wdata;
				if (host_addr == `VID_REG_BORDER)
					border <= host_wdata;
			end
			// a new underrun wins over a clear in the same cycle
			if (underrun)
				underrun_q <= 1'b1;
			else if (access && host_we && host_addr == `VID_REG_STATUS && host_wdata[0])
				underrun_q <= 1'b0;
		end
	end

	// read data sampled with the access, valid while ack is high
	always_ff @(posedge clk) begin
		if (access) begin
			case (host_addr)
				`VID_REG_CTRL:   host_rdata <= ctrl_q;
				`VID_REG_BORDER: host_rdata <= border;
				`VID_REG_STATUS: host_rdata <= {7'b0, underrun_q};
				default:         host_rdata <= 8'h00;
			endcase
		end
	end

endmodule

`default_nettype wire

//--- design/vid_stream_buf.sv
// circular FIFO with a four-phase req/ack push side and a pop/empty read side
`timescale 1ns/10ps
`default_nettype none

`include "vid_defs.svh"

module vid_stream_buf #(
	parameter type payload_t = logic [7:0]
) (
	input  wire      clk,
	input  wire      rst,
	input  wire      push_req,
	input  payload_t push_data,
	input  wire      pop,
	output logic     push_ack,
	output payload_t head,
	output logic     empty
);

	localparam int DEPTH = `VID_BUF_DEPTH;
	localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
	localparam int CNT_W = $clog2(DEPTH + 1);

	payload_t         mem [DEPTH];
	logic [PTR_W-1:0] wr_ptr;
	logic [PTR_W-1:0] rd_ptr;
	logic [CNT_W-1:0] count;
	logic             full;
	logic             do_push;
	logic             do_pop;

	assign full  = count == CNT_W'(DEPTH);
	assign empty = count == '0;
	assign head  = mem[rd_ptr];

	// accept only a req that has not been acked yet, and only with room
	assign do_push = push_req && !push_ack && !full;
	assign do_pop  = pop && !empty;

	always_ff @(posedge clk) begin
		if (do_push)
			mem[wr_ptr] <= push_data;
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			push_ack <= 1'b0;
			wr_ptr   <= '0;
			rd_ptr   <= '0;
			count    <= '0;
		end else begin
			// ack holds until req drops, then falls a cycle later
			if (do_push)
				push_ack <= 1'b1;
			else if (!push_req)
				push_ack <= 1'b0;
			if (do_push)
				wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
			if (do_pop)
				rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
			if (do_push && !do_pop)
				count <= count + 1'b1;
			else if (do_pop && !do_push)
				count <= count - 1'b1;
		end
	end

endmodule

`default_nettype wire

//--- design/vid_pixel_timer.sv
// horizontal pixel timer: strobe, line position, psel, buffer pops, flash, underrun
`timescale 1ns/10ps
`default_nettype none

`include "vid_defs.svh"

module vid_pixel_timer (
	input  wire                   clk,
	input  wire                   rst,
	input  vid_pkg::render_mode_t mode,
	input  wire                   gfx_empty,
	input  wire                   tile_empty,
	output logic                  pix_stb,
	output logic                  active,
	output logic [3:0]            psel,
	output logic                  flash,
	output logic                  gfx_valid,
	output logic                  gfx_pop,
	output logic                  tile_pop,
	output logic                  underrun
);

	localparam int H_TOTAL     = `VID_H_TOTAL;
	localparam int H_ACTIVE    = `VID_H_ACTIVE;
	localparam int CLK_PER_PIX = `VID_CLK_PER_PIX;
	localparam int FLASH_LINES = `VID_FLASH_LINES;
	localparam int DIV_W  = (CLK_PER_PIX > 1) ? $clog2(CLK_PER_PIX) : 1;
	localparam int HPOS_W = $clog2(H_TOTAL);
	localparam int LINE_W = (FLASH_LINES > 1) ? $clog2(FLASH_LINES) : 1;

	logic [DIV_W-1:0]  div_cnt;
	logic [HPOS_W-1:0] hpos;
	logic [LINE_W-1:0] line_cnt;
	logic [3:0]        psel_last;
	logic              word_first;
	logic              word_last;
	logic              word_ok;
	logic              gfx_claim;
	logic              line_end;

	assign pix_stb  = div_cnt == DIV_W'(CLK_PER_PIX - 1);
	assign active   = hpos < HPOS_W'(H_ACTIVE);
	assign line_end = hpos == HPOS_W'(H_TOTAL - 1);

	// last psel of a word per mode
	always_comb begin
		case (mode)
			vid_pkg::RM_HC: psel_last = 4'd3;
			vid_pkg::RM_XC: psel_last = 4'd1;
			default:        psel_last = 4'd15;
		endcase
	end

	assign word_first = psel == 4'd0;
	assign word_last  = psel >= psel_last;

	// word is claimed at its first pixel and held for the rest of it
	assign word_ok   = word_first ? !gfx_empty : gfx_claim;
	assign gfx_valid = word_ok && !tile_empty;

	// word leaves the buffer after its last pixel is shown
	assign gfx_pop  = pix_stb && active && word_ok && word_last;
	assign tile_pop = pix_stb && active && !tile_empty;
	assign underrun = pix_stb && active && ((word_first && gfx_empty) || tile_empty);

	always_ff @(posedge clk) begin
		if (rst) begin
			div_cnt   <= '0;
			hpos      <= '0;
			line_cnt  <= '0;
			psel      <= 4'd0;
			flash     <= 1'b0;
			gfx_claim <= 1'b0;
		end else begin
			div_cnt <= pix_stb ? '0 : div_cnt + 1'b1;
			if (pix_stb) begin
				hpos <= line_end ? '0 : hpos + 1'b1;
				if (active) begin
					psel <= word_last ? 4'd0 : psel + 4'd1;
					if (word_first)
						gfx_claim <= !gfx_empty;
				end else begin
					psel <= 4'd0;
				end
				// flash phase flips every few lines
				if (line_end) begin
					if (line_cnt == LINE_W'(FLASH_LINES - 1)) begin
						line_cnt <= '0;
						flash    <= !flash;
					end else begin
						line_cnt <= line_cnt + 1'b1;
					end
				end
			end
		end
	end

endmodule

`default_nettype wire

//--- design/vid_render.sv
// pixel renderer: per-mode decode, overlay and border plexing, hi-res packing
`timescale 1ns/10ps
`default_nettype none

module vid_render (
	input  wire                   clk,
	input  wire                   rst,
	input  wire                   pix_stb,
	input  wire                   active,
	input  wire                   gfx_valid,
	input  wire  [3:0]            psel,
	input  wire                   flash,
	input  vid_pkg::render_mode_t mode,
	input  wire                   hires,
	input  wire                   nogfx,
	input  wire  [3:0]            palsel,
	input  vid_pkg::pix_t         border,
	input  vid_pkg::gfx_word_t    gfx_word,
	input  vid_pkg::tile_byte_t   tile_byte,
	output logic                  vplex_valid,
	output vid_pkg::pix_t         vplex_out
);

	logic [15:0]   gfx_lo;
	logic [15:0]   gfx_hi;
	logic          dot;
	logic [7:0]    attr;
	logic [3:0]    nib;
	vid_pkg::pix_t zx_pix;
	vid_pkg::pix_t tx_pix;
	vid_pkg::pix_t hc_pix;
	vid_pkg::pix_t xc_pix;
	vid_pkg::pix_t gfx_pix;
	vid_pkg::pix_t video;
	logic [3:0]    prev_nib;

	assign gfx_lo = gfx_word[15:0];
	assign gfx_hi = gfx_word[31:16];

	// bitmap bit, MSB first within the byte picked by psel[3]
	assign dot  = gfx_lo[{psel[3], ~psel[2:0]}];
	assign attr = psel[3] ? gfx_hi[15:8] : gfx_hi[7:0];

	// ZX: bright bit, then ink or paper, flash inverts the dot
	assign zx_pix = (dot ^ (flash & attr[7])) ? {palsel, attr[6], attr[2:0]}
		: {palsel, attr[6], attr[5:3]};

	// text shares the bitmap path, attribute split into nibbles
	assign tx_pix = dot ? {palsel, attr[3:0]} : {palsel, attr[7:4]};

	// 16c nibble order 7:4, 3:0, 15:12, 11:8
	always_comb begin
		case (psel[1:0])
			2'd0:    nib = gfx_lo[7:4];
			2'd1:    nib = gfx_lo[3:0];
			2'd2:    nib = gfx_lo[15:12];
			default: nib = gfx_lo[11:8];
		endcase
	end
	assign hc_pix = {palsel, nib};

	// 256c low byte first
	assign xc_pix = psel[0] ? gfx_lo[15:8] : gfx_lo[7:0];

	always_comb begin
		case (mode)
			vid_pkg::RM_HC: gfx_pix = hc_pix;
			vid_pkg::RM_XC: gfx_pix = xc_pix;
			vid_pkg::RM_TX: gfx_pix = tx_pix;
			default:        gfx_pix = zx_pix;
		endcase
	end

	// border, then overlay, then graphics
	always_comb begin
		if (!active)
			video = border;
		else if (tile_byte[3:0] != 4'h0)
			video = tile_byte;
		else if (nogfx || !gfx_valid)
			video = border;
		else
			video = gfx_pix;
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			vplex_valid <= 1'b0;
			prev_nib    <= 4'h0;
		end else begin
			vplex_valid <= pix_stb;
			if (pix_stb)
				prev_nib <= video[3:0];
		end
	end

	// hi-res carries two 4-bit pixels per output
	always_ff @(posedge clk) begin
		if (pix_stb)
			vplex_out <= hires ? {prev_nib, video[3:0]} : video;
	end

endmodule

`default_nettype wire

//--- design/vid_top.sv
// video pipeline top: config regs, two stream buffers, pixel timer and renderer
`timescale 1ns/10ps
`default_nettype none

module vid_top (
	input  wire                 clk,
	input  wire                 rst,
	input  wire                 host_req,
	input  wire                 host_we,
	input  wire  [1:0]          host_addr,
	input  wire  [7:0]          host_wdata,
	output logic                host_ack,
	output logic [7:0]          host_rdata,
	input  wire                 gfx_req,
	input  vid_pkg::gfx_word_t  gfx_data,
	output logic                gfx_ack,
	input  wire                 tile_req,
	input  vid_pkg::tile_byte_t tile_data,
	output logic                tile_ack,
	output logic                vplex_valid,
	output vid_pkg::pix_t       vplex_out
);

	vid_pkg::render_mode_t mode;
	logic                  hires;
	logic                  nogfx;
	logic [3:0]            palsel;
	vid_pkg::pix_t         border;
	vid_pkg::gfx_word_t    gfx_head;
	vid_pkg::tile_byte_t   tile_head;
	logic                  gfx_empty;
	logic                  tile_empty;
	logic                  gfx_pop;
	logic                  tile_pop;
	logic                  pix_stb;
	logic                  active;
	logic [3:0]            psel;
	logic                  flash;
	logic                  gfx_valid;
	logic                  underrun;

	vid_config_regs regs_i (
		.clk(clk), .rst(rst), .host_req(host_req), .host_we(host_we),
		.host_addr(host_addr), .host_wdata(host_wdata), .underrun(underrun),
		.host_ack(host_ack), .host_rdata(host_rdata), .mode(mode), .hires(hires),
		.nogfx(nogfx), .palsel(palsel), .border(border)
	);

	vid_stream_buf #(.payload_t(vid_pkg::gfx_word_t)) gfx_buf_i (
		.clk(clk), .rst(rst), .push_req(gfx_req), .push_data(gfx_data), .pop(gfx_pop),
		.push_ack(gfx_ack), .head(gfx_head), .empty(gfx_empty)
	);

	vid_stream_buf #(.payload_t(vid_pkg::tile_byte_t)) tile_buf_i (
		.clk(clk), .rst(rst), .push_req(tile_req), .push_data(tile_data), .pop(tile_pop),
		.push_ack(tile_ack), .head(tile_head), .empty(tile_empty)
	);

	vid_pixel_timer timer_i (
		.clk(clk), .rst(rst), .mode(mode), .gfx_empty(gfx_empty), .tile_empty(tile_empty),
		.pix_stb(pix_stb), .active(active), .psel(psel), .flash(flash),
		.gfx_valid(gfx_valid), .gfx_pop(gfx_pop), .tile_pop(tile_pop), .underrun(underrun)
	);

	vid_render render_i (
		.clk(clk), .rst(rst), .pix_stb(pix_stb), .active(active), .gfx_valid(gfx_valid),
		.psel(psel), .flash(flash), .mode(mode), .hires(hires), .nogfx(nogfx),
		.palsel(palsel), .border(border), .gfx_word(gfx_head), .tile_byte(tile_head),
		.vplex_valid(vplex_valid), .vplex_out(vplex_out)
	);

endmodule

`default_nettype wire

//--- dv/vid_clock_gen.sv
// testbench clock and power-on reset
`timescale 1ns/10ps
`default_nettype none

module vid_clock_gen (
	output logic clk,
	output logic rst
);

	// 10 ns period
	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	initial begin
		rst = 1'b1;
		repeat (8) @(posedge clk);
		rst <= 1'b0;
	end

endmodule

`default_nettype wire

//--- dv/vid_properties.sv
// concurrent assertions on the req/ack handshakes and the pixel output strobe
`timescale 1ns/10ps
`default_nettype none

module vid_properties (
	input wire clk,
	input wire rst,
	input wire host_req,
	input wire host_ack,
	input wire gfx_req,
	input wire gfx_ack,
	input wire tile_req,
	input wire tile_ack,
	input wire vplex_valid
);

	// ack only rises on a req that is high
	host_ack_rise: assert property (@(posedge clk) disable iff (rst)
		$rose(host_ack) |-> $past(host_req)) else $error("host ack rose without req");
	gfx_ack_rise: assert property (@(posedge clk) disable iff (rst)
		$rose(gfx_ack) |-> $past(gfx_req)) else $error("gfx ack rose without req");
	tile_ack_rise: assert property (@(posedge clk) disable iff (rst)
		$rose(tile_ack) |-> $past(tile_req)) else $error("tile ack rose without req");

	// ack only falls once req has dropped
	host_ack_fall: assert property (@(posedge clk) disable iff (rst)
		$fell(host_ack) |-> !$past(host_req)) else $error("host ack fell with req high");
	gfx_ack_fall: assert property (@(posedge clk) disable iff (rst)
		$fell(gfx_ack) |-> !$past(gfx_req)) else $error("gfx ack fell with req high");
	tile_ack_fall: assert property (@(posedge clk) disable iff (rst)
		$fell(tile_ack) |-> !$past(tile_req)) else $error("tile ack fell with req high");

	// one cycle per output pixel
	valid_single: assert property (@(posedge clk) disable iff (rst)
		vplex_valid |=> !vplex_valid) else $error("vplex_valid high for two cycles");

endmodule

`default_nettype wire

//--- dv/vid_tb.sv
// directed testbench for the video pipeline: reference model, tests, compares, timeout
`timescale 1ns/10ps
`default_nettype none

`include "vid_defs.svh"

module vid_tb;

	localparam int LINE_PIX = `VID_H_TOTAL;
	localparam int LIMIT = 40 * `VID_H_TOTAL * `VID_CLK_PER_PIX + 200;

	logic clk;
	logic rst;
	logic host_req;
	logic host_we;
	logic [1:0] host_addr;
	logic [7:0] host_wdata;
	logic host_ack;
	logic [7:0] host_rdata;
	logic gfx_req;
	vid_pkg::gfx_word_t gfx_data;
	logic gfx_ack;
	logic tile_req;
	vid_pkg::tile_byte_t tile_data;
	logic tile_ack;
	logic vplex_valid;
	vid_pkg::pix_t vplex_out;

	// model state, updated at the falling edge
	vid_pkg::gfx_word_t gq[$];
	vid_pkg::tile_byte_t tq[$];
	logic [7:0] m_ctrl;
	logic [7:0] m_border;
	logic [3:0] m_psel;
	logic m_claim;
	logic [3:0] m_prev;
	logic m_prev_ok;
	logic host_ack_d;
	logic gfx_ack_d;
	logic tile_ack_d;
	int unsigned pix_n;
	int unsigned lines_done;
	int unsigned gfx_pops;
	vid_pkg::pix_t line_exp[LINE_PIX];
	vid_pkg::pix_t line_act[LINE_PIX];
	logic line_ok[LINE_PIX];
	int unsigned errors;
	int unsigned checks;
	int unsigned tests;
	int unsigned cycles;

	vid_clock_gen clk_gen_i (.clk(clk), .rst(rst));

	vid_top dut_i (.*);

	bind vid_top vid_properties props_i (.*);

	// pixel value from the mode rules
	function automatic vid_pkg::pix_t decode_pixel(input vid_pkg::render_mode_t mode,
			input logic [3:0] pal, input vid_pkg::gfx_word_t w, input logic [3:0] ps,
			input logic fl);
		logic [7:0] bits;
		logic [7:0] attr;
		logic dot;
		bits = ps[3] ? w[15:8] : w[7:0];
		attr = ps[3] ? w[31:24] : w[23:16];
		dot = bits[3'd7 - ps[2:0]];
		case (mode)
			vid_pkg::RM_ZX: begin
				if (dot ^ (fl & attr[7]))
					return {pal, attr[6], attr[2:0]};
				return {pal, attr[6], attr[5:3]};
			end
			vid_pkg::RM_TX: return dot ? {pal, attr[3:0]} : {pal, attr[7:4]};
			vid_pkg::RM_HC: begin
				case (ps[1:0])
					2'd0: return {pal, w[7:4]};
					2'd1: return {pal, w[3:0]};
					2'd2: return {pal, w[15:12]};
					default: return {pal, w[11:8]};
				endcase
			end
			default: return ps[0] ? w[15:8] : w[7:0];
		endcase
	endfunction

	// one output pixel of the reference model
	task automatic model_pixel();
		int unsigned hpos;
		logic [3:0] last;
		logic known;
		logic fl;
		vid_pkg::pix_t video;
		hpos = pix_n % LINE_PIX;
		fl = ((pix_n / LINE_PIX / `VID_FLASH_LINES) % 2) == 1;
		known = 1'b1;
		video = m_border;
		if (hpos < `VID_H_ACTIVE) begin
			case (m_ctrl[1:0])
				2'd1: last = 4'd3;
				2'd2: last = 4'd1;
				default: last = 4'd15;
			endcase
			if (m_psel == 4'd0)
				m_claim = gq.size() > 0;
			// a starved overlay leaves a stale head, so the pixel is skipped
			if (tq.size() == 0)
				known = 1'b0;
			else if (tq[0][3:0] != 4'h0)
				video = tq[0];
			else if (!m_ctrl[3] && m_claim)
				video = decode_pixel(vid_pkg::render_mode_t'(m_ctrl[1:0]), m_ctrl[7:4],
					gq[0], m_psel, fl);
			if (tq.size() > 0)
				void'(tq.pop_front());
			if (m_claim && m_psel >= last) begin
				void'(gq.pop_front());
				gfx_pops++;
			end
			m_psel = (m_psel >= last) ? 4'd0 : m_psel + 4'd1;
		end else begin
			m_psel = 4'd0;
		end
		line_exp[hpos] = m_ctrl[2] ? {m_prev, video[3:0]} : video;
		line_ok[hpos] = known && (!m_ctrl[2] || m_prev_ok);
		line_act[hpos] = vplex_out;
		m_prev = video[3:0];
		m_prev_ok = known;
		pix_n++;
		if (hpos == LINE_PIX - 1)
			lines_done++;
	endtask

	always @(negedge clk) begin
		if (rst) begin
			gq.delete();
			tq.delete();
			m_ctrl = 8'h00;
			m_border = 8'h00;
			m_psel = 4'd0;
			m_claim = 1'b0;
			m_prev = 4'h0;
			m_prev_ok = 1'b1;
			pix_n = 0;
		end else begin
			// pixel first, it saw the state before this edge
			if (vplex_valid)
				model_pixel();
			if (gfx_ack && !gfx_ack_d)
				gq.push_back(gfx_data);
			if (tile_ack && !tile_ack_d)
				tq.push_back(tile_data);
			if (host_ack && !host_ack_d && host_we) begin
				if (host_addr == `VID_REG_CTRL)
					m_ctrl = host_wdata;
				if (host_addr == `VID_REG_BORDER)
					m_border = host_wdata;
			end
		end
		host_ack_d = host_ack;
		gfx_ack_d = gfx_ack;
		tile_ack_d = tile_ack;
	end

	task automatic check_pix(input string name, input vid_pkg::pix_t exp, input vid_pkg::pix_t act);
		checks++;
		if (exp !== act) begin
			errors++;
			$display("CHECK FAILED %s: expected %02h, actual %02h", name, exp, act);
		end
	endtask

	task automatic check_reg(input string name, input logic [7:0] exp, input logic [7:0] act);
		checks++;
		if (exp !== act) begin
			errors++;
			$display("CHECK FAILED %s: expected %02h, actual %02h", name, exp, act);
		end
	endtask

	task automatic check_flag(input string name, input logic exp, input logic act);
		checks++;
		if (exp !== act) begin
			errors++;
			$display("CHECK FAILED %s: expected %0b, actual %0b", name, exp, act);
		end
	endtask

	task automatic host_access(input logic we, input logic [1:0] addr, input logic [7:0] wdata,
			output logic [7:0] rdata);
		@(posedge clk);
		host_req <= 1'b1;
		host_we <= we;
		host_addr <= addr;
		host_wdata <= wdata;
		@(negedge clk);
		while (!host_ack)
			@(negedge clk);
		rdata = host_rdata;
		@(posedge clk);
		host_req <= 1'b0;
		@(negedge clk);
		check_flag("host ack held until req falls", 1'b1, host_ack);
		while (host_ack)
			@(negedge clk);
	endtask

	task automatic host_write(input logic [1:0] addr, input logic [7:0] wdata);
		logic [7:0] unused;
		host_access(1'b1, addr, wdata, unused);
	endtask

	task automatic host_read(input logic [1:0] addr, output logic [7:0] rdata);
		host_access(1'b0, addr, 8'h00, rdata);
	endtask

	task automatic push_gfx(input vid_pkg::gfx_word_t w, output int unsigned waited);
		@(posedge clk);
		gfx_req <= 1'b1;
		gfx_data <= w;
		waited = 0;
		@(negedge clk);
		while (!gfx_ack) begin
			waited++;
			@(negedge clk);
		end
		@(posedge clk);
		gfx_req <= 1'b0;
		@(negedge clk);
		while (gfx_ack)
			@(negedge clk);
	endtask

	task automatic push_tile(input vid_pkg::tile_byte_t t);
		@(posedge clk);
		tile_req <= 1'b1;
		tile_data <= t;
		@(negedge clk);
		while (!tile_ack)
			@(negedge clk);
		@(posedge clk);
		tile_req <= 1'b0;
		@(negedge clk);
		while (tile_ack)
			@(negedge clk);
	endtask

	// random words, and overlay bytes that are opaque one time in four
	task automatic feed(input int n_gfx, input int n_tile, input logic opaque);
		fork
			for (int i = 0; i < n_gfx; i++) begin
				int unsigned waited;
				push_gfx($urandom(), waited);
			end
			for (int i = 0; i < n_tile; i++) begin
				logic [31:0] r;
				r = $urandom();
				push_tile((opaque && r[9:8] == 2'd0) ? r[7:0] : {r[7:4], 4'h0});
			end
		join
	endtask

	task automatic collect_line(input string name, inout int unsigned checked);
		int unsigned start;
		start = lines_done;
		wait (lines_done != start);
		for (int i = 0; i < LINE_PIX; i++) begin
			if (line_ok[i]) begin
				check_pix(name, line_exp[i], line_act[i]);
				checked++;
			end
		end
	endtask

	task automatic run_lines(input string name, input int n, input int n_gfx, input logic opaque);
		int unsigned checked;
		int unsigned err0;
		checked = 0;
		err0 = errors;
		fork
			feed(n_gfx, 20 * n, opaque);
			for (int i = 0; i < n; i++)
				collect_line(name, checked);
		join
		if (checked == 0) begin
			errors++;
			$display("%s: no pixel could be checked", name);
		end
		tests++;
		$display("test %s done, %0d pixels checked, %0d errors", name, checked, errors - err0);
	endtask

	task automatic reg_round_trip();
		logic [7:0] rd;
		int unsigned err0;
		err0 = errors;
		host_write(`VID_REG_CTRL, 8'h5a);
		host_read(`VID_REG_CTRL, rd);
		check_reg("ctrl readback", 8'h5a, rd);
		host_write(`VID_REG_BORDER, 8'hc3);
		host_read(`VID_REG_BORDER, rd);
		check_reg("border readback", 8'hc3, rd);
		tests++;
		$display("test reg_round_trip done, %0d errors", errors - err0);
	endtask

	task automatic underrun_and_backpressure();
		logic [7:0] rd;
		int unsigned err0;
		int unsigned pops;
		int unsigned waited;
		int unsigned checked;
		int n;
		err0 = errors;
		checked = 0;
		host_write(`VID_REG_CTRL, 8'h01);
		// status access inside the border, where no underrun fires
		wait ((pix_n % LINE_PIX) == `VID_H_ACTIVE + 1);
		host_write(`VID_REG_STATUS, 8'h01);
		host_read(`VID_REG_STATUS, rd);
		check_reg("status before starving", 8'h00, rd);
		// no graphics words, so active pixels fall back to the border
		fork
			feed(0, 40, 1'b0);
			repeat (2) collect_line("underrun_border", checked);
		join
		wait ((pix_n % LINE_PIX) == `VID_H_ACTIVE + 1);
		host_read(`VID_REG_STATUS, rd);
		check_reg("status after starving", 8'h01, rd);
		host_write(`VID_REG_STATUS, 8'h01);
		host_read(`VID_REG_STATUS, rd);
		check_reg("status after clear", 8'h00, rd);
		// fill the gfx buffer during the border, then one more
		host_write(`VID_REG_CTRL, 8'h00);
		wait ((pix_n % LINE_PIX) == `VID_H_ACTIVE + 1);
		n = `VID_BUF_DEPTH - gq.size();
		for (int i = 0; i < n; i++)
			push_gfx($urandom(), waited);
		pops = gfx_pops;
		push_gfx($urandom(), waited);
		check_flag("ninth push acked only after a pop", 1'b1, gfx_pops != pops);
		check_flag("ninth push held back", 1'b1, waited > 4);
		tests++;
		$display("test underrun_and_backpressure done, %0d errors", errors - err0);
	endtask

	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (cycles > LIMIT) begin
			$display("timeout: run did not finish within %0d cycles", LIMIT);
			$display("Test failures found");
			$finish;
		end
	end

	initial begin
		host_req = 1'b0;
		host_we = 1'b0;
		host_addr = 2'd0;
		host_wdata = 8'h00;
		gfx_req = 1'b0;
		gfx_data = '0;
		tile_req = 1'b0;
		tile_data = '0;
		errors = 0;
		checks = 0;
		tests = 0;
		cycles = 0;
		lines_done = 0;
		gfx_pops = 0;
		void'($urandom(32'h1552_cf80));
		wait (!rst);
		reg_round_trip();
		host_write(`VID_REG_BORDER, 8'h2b);
		host_write(`VID_REG_CTRL, 8'h08);
		run_lines("border_nogfx", 2, 4, 1'b0);
		host_write(`VID_REG_CTRL, 8'h00);
		run_lines("border_inactive", 1, 2, 1'b0);
		host_write(`VID_REG_CTRL, 8'h71);
		run_lines("decode_16c", 2, 16, 1'b1);
		host_write(`VID_REG_CTRL, 8'h02);
		run_lines("decode_256c", 2, 28, 1'b1);
		host_write(`VID_REG_CTRL, 8'h30);
		run_lines("decode_zx_flash", 5, 10, 1'b0);
		host_write(`VID_REG_CTRL, 8'h43);
		run_lines("decode_text", 2, 4, 1'b0);
		host_write(`VID_REG_CTRL, 8'h05);
		run_lines("hires_packing", 2, 16, 1'b1);
		underrun_and_backpressure();
		$display("%0d tests, %0d checks, %0d errors", tests, checks, errors);
		if (errors == 0)
			$display("All tests passed!");
		else
			$display("Test failures found");
		$finish;
	end

endmodule

`default_nettype wire

//--- vid_subsys.f
+incdir+include
design/vid_pkg.sv
design/vid_config_regs.sv
design/vid_stream_buf.sv
design/vid_pixel_timer.sv
design/vid_render.sv
design/vid_top.sv
dv/vid_clock_gen.sv
dv/vid_properties.sv
dv/vid_tb.sv

//--- Makefile
# Verilator flow for the video pipeline

TOP := vid_tb

.PHONY: lint sim clean

lint:
	verilator --lint-only -Wall --timing --assert -f vid_subsys.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert -f vid_subsys.f --top-module $(TOP) -Mdir obj_dir
	./obj_dir/V$(TOP) | tee /dev/stderr | grep -q "All tests passed!"

clean:
	rm -rf obj_dir
